// ==== hw/reflex_pkg.sv ====
package reflex_pkg;

    ////////////////////
    // widths
    ////////////////////

    // one data, gain, current or count word
    localparam int WORD_W = 32;
    // one host wire
    localparam int HALF_W = 16;
    // trigger strobe vector
    localparam int TRIG_W = 16;
    // full multiplier product before truncation
    localparam int PROD_W = 2 * WORD_W;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [HALF_W-1:0] half_word_t;
    typedef logic [TRIG_W-1:0] trig_t;

    ////////////////////
    // trigger indices
    ////////////////////

    // neuron tick half-count
    localparam int TRIG_HALF_CNT    = 0;
    localparam int TRIG_GAIN_CN_MN  = 3;
    localparam int TRIG_GAIN_SN_MN  = 6;
    // cortical drive into cn2
    localparam int TRIG_DRIVE_CN2   = 8;
    localparam int TRIG_GAIN_CN2_MN = 9;
    // cortical drive into cn
    localparam int TRIG_DRIVE_CN    = 11;
    localparam int TRIG_GAIN_SN_CN  = 12;

    ////////////////////
    // reset defaults
    ////////////////////

    // tick period is half-count plus one cycles
    localparam word_t DEF_HALF_CNT = 32'd9;
    // unity gain
    localparam word_t DEF_GAIN     = 32'd1;
    // no cortical drive
    localparam word_t DEF_DRIVE    = 32'd0;

    // neuron ticks per spike counting window
    localparam int WINDOW_TICKS = 4;

endpackage

// ==== hw/param_bank.sv ====
module param_bank (
    input  logic                   ep50trig,
    input  logic                   reset_sim,
    input  reflex_pkg::trig_t      i_trig,
    input  reflex_pkg::half_word_t i_wire_lo,
    input  reflex_pkg::half_word_t i_wire_hi,
    output reflex_pkg::word_t      o_half_cnt,
    output reflex_pkg::word_t      o_gain_sn_mn,
    output reflex_pkg::word_t      o_gain_sn_cn,
    output reflex_pkg::word_t      o_gain_cn_mn,
    output reflex_pkg::word_t      o_gain_cn2_mn,
    output reflex_pkg::word_t      o_drive_cn,
    output reflex_pkg::word_t      o_drive_cn2
);

    import reflex_pkg::*;

    // load word with the upper half from the high wire
    word_t load_word;

    assign load_word = {i_wire_hi, i_wire_lo};

    ////////////////////
    // tick rate
    ////////////////////

    // half-count of the neuron tick divider
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            o_half_cnt <= DEF_HALF_CNT;
        end
        else if (i_trig[TRIG_HALF_CNT])
        begin
            o_half_cnt <= load_word;
        end
    end

    ////////////////////
    // synapse gains
    ////////////////////

    // each gain has its own strobe bit
    // several bits in one cycle load several gains from the same word
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            o_gain_sn_mn  <= DEF_GAIN;
            o_gain_sn_cn  <= DEF_GAIN;
            o_gain_cn_mn  <= DEF_GAIN;
            o_gain_cn2_mn <= DEF_GAIN;
        end
        else
        begin
            // spinal path
            if (i_trig[TRIG_GAIN_SN_MN])
            begin
                o_gain_sn_mn <= load_word;
            end
            // sensory into both cortical pools
            if (i_trig[TRIG_GAIN_SN_CN])
            begin
                o_gain_sn_cn <= load_word;
            end
            // transcortical paths into mn
            if (i_trig[TRIG_GAIN_CN_MN])
            begin
                o_gain_cn_mn <= load_word;
            end
            if (i_trig[TRIG_GAIN_CN2_MN])
            begin
                o_gain_cn2_mn <= load_word;
            end
        end
    end

    ////////////////////
    // cortical drives
    ////////////////////

    // direct voluntary command added to the cn and cn2 currents
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            o_drive_cn  <= DEF_DRIVE;
            o_drive_cn2 <= DEF_DRIVE;
        end
        else
        begin
            if (i_trig[TRIG_DRIVE_CN])
            begin
                o_drive_cn <= load_word;
            end
            if (i_trig[TRIG_DRIVE_CN2])
            begin
                o_drive_cn2 <= load_word;
            end
        end
    end

endmodule

// ==== hw/neuron_tick_gen.sv ====
module neuron_tick_gen (
    input  logic              ep50trig,
    input  logic              reset_sim,
    input  reflex_pkg::word_t i_half_cnt,
    output logic              o_tick
);

    import reflex_pkg::*;

    // free-running cycle count within one neuron period
    word_t cycle_cnt;

    ////////////////////
    // tick decode
    ////////////////////

    // high once the count reaches the half-count
    // live compare lets a new half-count act in the current period
    // a half-count below the count fires on the next cycle
    assign o_tick = (cycle_cnt >= i_half_cnt);

    ////////////////////
    // cycle counter
    ////////////////////

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            cycle_cnt <= '0;
        end
        else if (o_tick)
        begin
            // period wraps after the tick cycle
            cycle_cnt <= '0;
        end
        else
        begin
            cycle_cnt <= cycle_cnt + 32'd1;
        end
    end

endmodule

// ==== hw/drive_network.sv ====
module drive_network (
    input  logic              ep50trig,
    input  logic              reset_sim,
    input  logic              i_tick,
    input  reflex_pkg::word_t i_epsc_sn_mn_pre,
    input  reflex_pkg::word_t i_epsc_sn_cn_pre,
    input  reflex_pkg::word_t i_epsc_sn_cn2_pre,
    input  reflex_pkg::word_t i_epsc_cn_mn_pre,
    input  reflex_pkg::word_t i_epsc_cn2_mn_pre,
    input  reflex_pkg::word_t i_gain_sn_mn,
    input  reflex_pkg::word_t i_gain_sn_cn,
    input  reflex_pkg::word_t i_gain_cn_mn,
    input  reflex_pkg::word_t i_gain_cn2_mn,
    input  reflex_pkg::word_t i_drive_cn,
    input  reflex_pkg::word_t i_drive_cn2,
    output reflex_pkg::word_t o_drive_cn,
    output reflex_pkg::word_t o_drive_cn2,
    output reflex_pkg::word_t o_drive_mn,
    output reflex_pkg::word_t o_epsc_sn_mn,
    output reflex_pkg::word_t o_epsc_cn_mn
);

    import reflex_pkg::*;

    // unsigned multiply keeping the low word of the product
    function automatic word_t gain_mult(input word_t a, input word_t b);
        logic [PROD_W-1:0] prod;
        prod = a * b;
        return prod[WORD_W-1:0];
    endfunction

    // gained epscs
    word_t epsc_sn_mn;
    word_t epsc_sn_cn;
    word_t epsc_sn_cn2;
    word_t epsc_cn_mn;
    word_t epsc_cn2_mn;

    // unlatched drive sums
    word_t drive_cn_d;
    word_t drive_cn2_d;
    word_t drive_mn_d;

    ////////////////////
    // synapse gains
    ////////////////////

    assign epsc_sn_mn  = gain_mult(i_epsc_sn_mn_pre, i_gain_sn_mn);
    assign epsc_sn_cn  = gain_mult(i_epsc_sn_cn_pre, i_gain_sn_cn);
    // cn2 reuses the sn to cn gain
    assign epsc_sn_cn2 = gain_mult(i_epsc_sn_cn2_pre, i_gain_sn_cn);
    assign epsc_cn_mn  = gain_mult(i_epsc_cn_mn_pre, i_gain_cn_mn);
    assign epsc_cn2_mn = gain_mult(i_epsc_cn2_mn_pre, i_gain_cn2_mn);

    ////////////////////
    // current sums
    ////////////////////

    // sensory plus cortical command
    assign drive_cn_d  = epsc_sn_cn + i_drive_cn;
    assign drive_cn2_d = epsc_sn_cn2 + i_drive_cn2;
    // spinal plus both transcortical paths wrapping mod 2^32
    assign drive_mn_d  = epsc_sn_mn + epsc_cn_mn + epsc_cn2_mn;

    ////////////////////
    // per-tick latch
    ////////////////////

    // sampled once per neuron period and held in between
    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            o_drive_cn   <= '0;
            o_drive_cn2  <= '0;
            o_drive_mn   <= '0;
            o_epsc_sn_mn <= '0;
            o_epsc_cn_mn <= '0;
        end
        else if (i_tick)
        begin
            o_drive_cn   <= drive_cn_d;
            o_drive_cn2  <= drive_cn2_d;
            o_drive_mn   <= drive_mn_d;
            // readouts of two gained paths
            o_epsc_sn_mn <= epsc_sn_mn;
            o_epsc_cn_mn <= epsc_cn_mn;
        end
    end

endmodule

// ==== hw/spike_window_counter.sv ====
module spike_window_counter (
    input  logic              ep50trig,
    input  logic              reset_sim,
    input  logic              i_tick,
    input  logic              i_spike,
    output reflex_pkg::word_t o_count
);

    import reflex_pkg::*;

    // spikes seen so far in this window
    word_t spike_cnt;
    // ticks seen so far in this window
    word_t tick_cnt;
    // last tick of the window
    logic  window_end;

    // spike pulse widened to a word for the adder
    word_t spike_inc;

    assign spike_inc  = {{(WORD_W-1){1'b0}}, i_spike};
    assign window_end = i_tick && (tick_cnt == word_t'(WINDOW_TICKS - 1));

    ////////////////////
    // window counters
    ////////////////////

    always_ff @(posedge ep50trig or posedge reset_sim)
    begin
        if (reset_sim)
        begin
            spike_cnt <= '0;
            tick_cnt  <= '0;
            o_count   <= '0;
        end
        else if (window_end)
        begin
            // publish with a spike in the boundary cycle counted too
            o_count   <= spike_cnt + spike_inc;
            spike_cnt <= '0;
            tick_cnt  <= '0;
        end
        else
        begin
            spike_cnt <= spike_cnt + spike_inc;
            if (i_tick)
            begin
                tick_cnt <= tick_cnt + 32'd1;
            end
        end
    end

endmodule

// ==== hw/reflex_loop_top.sv ====
module reflex_loop_top (
    input  logic                   ep50trig,
    input  logic                   reset_sim,
    input  reflex_pkg::trig_t      i_trig,
    input  reflex_pkg::half_word_t i_wire_lo,
    input  reflex_pkg::half_word_t i_wire_hi,
    input  reflex_pkg::word_t      i_epsc_sn_mn_pre,
    input  reflex_pkg::word_t      i_epsc_sn_cn_pre,
    input  reflex_pkg::word_t      i_epsc_sn_cn2_pre,
    input  reflex_pkg::word_t      i_epsc_cn_mn_pre,
    input  reflex_pkg::word_t      i_epsc_cn2_mn_pre,
    input  logic                   i_sn_spike,
    input  logic                   i_mn_spike,
    output logic                   o_neuron_tick,
    output reflex_pkg::word_t      o_drive_cn,
    output reflex_pkg::word_t      o_drive_cn2,
    output reflex_pkg::word_t      o_drive_mn,
    output reflex_pkg::word_t      o_epsc_sn_mn,
    output reflex_pkg::word_t      o_epsc_cn_mn,
    output reflex_pkg::word_t      o_sn_spkcnt,
    output reflex_pkg::word_t      o_mn_spkcnt
);

    import reflex_pkg::*;

    // loaded parameters
    word_t half_cnt;
    word_t gain_sn_mn;
    word_t gain_sn_cn;
    word_t gain_cn_mn;
    word_t gain_cn2_mn;
    word_t drive_cn;
    word_t drive_cn2;

    ////////////////////
    // parameters
    ////////////////////

    param_bank u_param_bank (
        .ep50trig      (ep50trig),
        .reset_sim     (reset_sim),
        .i_trig        (i_trig),
        .i_wire_lo     (i_wire_lo),
        .i_wire_hi     (i_wire_hi),
        .o_half_cnt    (half_cnt),
        .o_gain_sn_mn  (gain_sn_mn),
        .o_gain_sn_cn  (gain_sn_cn),
        .o_gain_cn_mn  (gain_cn_mn),
        .o_gain_cn2_mn (gain_cn2_mn),
        .o_drive_cn    (drive_cn),
        .o_drive_cn2   (drive_cn2)
    );

    // neuron rate
    neuron_tick_gen u_tick_gen (
        .ep50trig   (ep50trig),
        .reset_sim  (reset_sim),
        .i_half_cnt (half_cnt),
        .o_tick     (o_neuron_tick)
    );

    ////////////////////
    // currents
    ////////////////////

    drive_network u_drive_network (
        .ep50trig          (ep50trig),
        .reset_sim         (reset_sim),
        .i_tick            (o_neuron_tick),
        .i_epsc_sn_mn_pre  (i_epsc_sn_mn_pre),
        .i_epsc_sn_cn_pre  (i_epsc_sn_cn_pre),
        .i_epsc_sn_cn2_pre (i_epsc_sn_cn2_pre),
        .i_epsc_cn_mn_pre  (i_epsc_cn_mn_pre),
        .i_epsc_cn2_mn_pre (i_epsc_cn2_mn_pre),
        .i_gain_sn_mn      (gain_sn_mn),
        .i_gain_sn_cn      (gain_sn_cn),
        .i_gain_cn_mn      (gain_cn_mn),
        .i_gain_cn2_mn     (gain_cn2_mn),
        .i_drive_cn        (drive_cn),
        .i_drive_cn2       (drive_cn2),
        .o_drive_cn        (o_drive_cn),
        .o_drive_cn2       (o_drive_cn2),
        .o_drive_mn        (o_drive_mn),
        .o_epsc_sn_mn      (o_epsc_sn_mn),
        .o_epsc_cn_mn      (o_epsc_cn_mn)
    );

    ////////////////////
    // spike counts
    ////////////////////

    // sensory pool
    spike_window_counter u_sn_counter (
        .ep50trig  (ep50trig),
        .reset_sim (reset_sim),
        .i_tick    (o_neuron_tick),
        .i_spike   (i_sn_spike),
        .o_count   (o_sn_spkcnt)
    );

    // motor pool
    spike_window_counter u_mn_counter (
        .ep50trig  (ep50trig),
        .reset_sim (reset_sim),
        .i_tick    (o_neuron_tick),
        .i_spike   (i_mn_spike),
        .o_count   (o_mn_spkcnt)
    );

endmodule

// ==== bench/reflex_loop_assert.sv ====
module reflex_loop_assert (
    input logic              ep50trig,
    input logic              reset_sim,
    input logic              i_tick,
    input reflex_pkg::word_t o_drive_cn,
    input reflex_pkg::word_t o_drive_cn2,
    input reflex_pkg::word_t o_drive_mn,
    input reflex_pkg::word_t o_epsc_sn_mn,
    input reflex_pkg::word_t o_epsc_cn_mn
);

    timeunit 1ns;
    timeprecision 1ps;

    import reflex_pkg::*;

    // failed checks so far
    int fail_cnt = 0;

    // whole latch bank as one vector
    logic [5*WORD_W-1:0] all_out;

    assign all_out = {o_drive_cn, o_drive_cn2, o_drive_mn, o_epsc_sn_mn, o_epsc_cn_mn};

    ////////////////////
    // latch timing
    ////////////////////

    // moves only on the edge after a tick cycle
    a_hold_between_ticks: assert property (@(posedge ep50trig) disable iff (reset_sim)
        !$past(i_tick) |-> $stable(all_out))
    else
    begin
        $error("drive outputs changed without a tick in the previous cycle");
        fail_cnt++;
    end

    // cleared while reset is high
    a_zero_in_reset: assert property (@(posedge ep50trig) reset_sim |-> (all_out == '0))
    else
    begin
        $error("drive outputs not zero during reset");
        fail_cnt++;
    end

endmodule

bind drive_network reflex_loop_assert u_assert (
    .ep50trig     (ep50trig),
    .reset_sim    (reset_sim),
    .i_tick       (i_tick),
    .o_drive_cn   (o_drive_cn),
    .o_drive_cn2  (o_drive_cn2),
    .o_drive_mn   (o_drive_mn),
    .o_epsc_sn_mn (o_epsc_sn_mn),
    .o_epsc_cn_mn (o_epsc_cn_mn)
);

// ==== bench/tb_reflex_loop.sv ====
module tb_reflex_loop;

    timeunit 1ns;
    timeprecision 1ps;

    import reflex_pkg::*;

    // cycles over all phases, and the longest neuron period that can be loaded
    localparam int N_CYC   = 600;
    localparam int MAX_PER = 21;

    logic       ep50trig;
    logic       reset_sim;
    trig_t      i_trig;
    half_word_t i_wire_lo, i_wire_hi;
    word_t      i_epsc_sn_mn_pre, i_epsc_sn_cn_pre, i_epsc_sn_cn2_pre;
    word_t      i_epsc_cn_mn_pre, i_epsc_cn2_mn_pre;
    logic       i_sn_spike, i_mn_spike;
    logic       o_neuron_tick;
    word_t      o_drive_cn, o_drive_cn2, o_drive_mn;
    word_t      o_epsc_sn_mn, o_epsc_cn_mn;
    word_t      o_sn_spkcnt, o_mn_spkcnt;

    integer seed = 32'hc814;

    // model parameter registers
    word_t m_half, m_g_sn_mn, m_g_sn_cn, m_g_cn_mn, m_g_cn2_mn, m_d_cn, m_d_cn2;
    // model latched outputs
    word_t m_drive_cn, m_drive_cn2, m_drive_mn, m_epsc_sn_mn, m_epsc_cn_mn;
    // model tick divider and spike windows
    word_t m_cnt, m_sn_run, m_mn_run, m_sn_cnt, m_mn_cnt;
    int    m_ticks;

    reflex_loop_top UUT (.*);

    always #4 ep50trig = ~ep50trig;

    ////////////////////
    // compare tasks
    ////////////////////

    task automatic stop_on_error();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_tick(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("Error at %0t ns: %s expected %b, actual %b", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
        begin
            $display("Error at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_count(input string name, input word_t exp, input word_t act);
        if (act !== exp)
        begin
            $display("Error at %0t ns: %s expected %0d, actual %0d", $time, name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_outputs();
        check_tick("o_neuron_tick", m_cnt >= m_half, o_neuron_tick);
        check_word("o_drive_cn", m_drive_cn, o_drive_cn);
        check_word("o_drive_cn2", m_drive_cn2, o_drive_cn2);
        check_word("o_drive_mn", m_drive_mn, o_drive_mn);
        check_word("o_epsc_sn_mn", m_epsc_sn_mn, o_epsc_sn_mn);
        check_word("o_epsc_cn_mn", m_epsc_cn_mn, o_epsc_cn_mn);
        check_count("o_sn_spkcnt", m_sn_cnt, o_sn_spkcnt);
        check_count("o_mn_spkcnt", m_mn_cnt, o_mn_spkcnt);
    endtask

    ////////////////////
    // reference model
    ////////////////////

    // one rising edge with all next values from the old state
    task automatic model_edge();
        logic  tk;
        logic  last;
        word_t ld;
        tk   = (m_cnt >= m_half);
        last = tk && (m_ticks == WINDOW_TICKS - 1);
        ld   = {i_wire_hi, i_wire_lo};
        if (tk)
        begin
            // products keep the low word and sums wrap
            m_epsc_sn_mn = i_epsc_sn_mn_pre * m_g_sn_mn;
            m_epsc_cn_mn = i_epsc_cn_mn_pre * m_g_cn_mn;
            m_drive_cn   = i_epsc_sn_cn_pre * m_g_sn_cn + m_d_cn;
            m_drive_cn2  = i_epsc_sn_cn2_pre * m_g_sn_cn + m_d_cn2;
            m_drive_mn   = m_epsc_sn_mn + m_epsc_cn_mn + i_epsc_cn2_mn_pre * m_g_cn2_mn;
        end
        if (last)
        begin
            m_sn_cnt = m_sn_run + i_sn_spike;
            m_mn_cnt = m_mn_run + i_mn_spike;
            m_sn_run = '0;
            m_mn_run = '0;
            m_ticks  = 0;
        end
        else
        begin
            m_sn_run = m_sn_run + i_sn_spike;
            m_mn_run = m_mn_run + i_mn_spike;
            m_ticks  = tk ? m_ticks + 1 : m_ticks;
        end
        m_cnt = tk ? '0 : m_cnt + 1;
        // register loads last so they show from the next cycle
        if (i_trig[TRIG_HALF_CNT])    m_half     = ld;
        if (i_trig[TRIG_GAIN_SN_MN])  m_g_sn_mn  = ld;
        if (i_trig[TRIG_GAIN_SN_CN])  m_g_sn_cn  = ld;
        if (i_trig[TRIG_GAIN_CN_MN])  m_g_cn_mn  = ld;
        if (i_trig[TRIG_GAIN_CN2_MN]) m_g_cn2_mn = ld;
        if (i_trig[TRIG_DRIVE_CN])    m_d_cn     = ld;
        if (i_trig[TRIG_DRIVE_CN2])   m_d_cn2    = ld;
    endtask

    ////////////////////
    // stimulus
    ////////////////////

    // mode 0 no loads, 1 random masks without bit 0, 2 half-count reloads
    task automatic apply_inputs(input int mode);
        word_t ld;
        i_trig = '0;
        ld     = $random(seed);
        if (mode == 1 && $unsigned($random(seed)) % 3 == 0)
        begin
            i_trig = trig_t'($random(seed)) & 16'hfffe;
        end
        if (mode == 2 && $unsigned($random(seed)) % 12 == 0)
        begin
            i_trig = 16'h0001;
            ld     = $unsigned($random(seed)) % 21;
        end
        i_wire_hi         = ld[31:16];
        i_wire_lo         = ld[15:0];
        i_epsc_sn_mn_pre  = $random(seed);
        i_epsc_sn_cn_pre  = $random(seed);
        i_epsc_sn_cn2_pre = $random(seed);
        i_epsc_cn_mn_pre  = $random(seed);
        i_epsc_cn2_mn_pre = $random(seed);
        i_sn_spike        = ($random(seed) & 1) != 0;
        i_mn_spike        = ($random(seed) & 1) != 0;
    endtask

    task automatic run_phase(input int n, input int mode);
        repeat (n)
        begin
            @(posedge ep50trig);
            model_edge();
            #1;
            check_outputs();
            apply_inputs(mode);
        end
    endtask

    initial
    begin
        ep50trig  = 1'b0;
        reset_sim = 1'b0;
        i_trig    = '0;
        {i_wire_hi, i_wire_lo} = '0;
        {i_epsc_sn_mn_pre, i_epsc_sn_cn_pre, i_epsc_sn_cn2_pre} = '0;
        {i_epsc_cn_mn_pre, i_epsc_cn2_mn_pre} = '0;
        {i_sn_spike, i_mn_spike} = '0;
        // model reset values
        m_half = DEF_HALF_CNT;
        {m_g_sn_mn, m_g_sn_cn, m_g_cn_mn, m_g_cn2_mn} = {4{DEF_GAIN}};
        {m_d_cn, m_d_cn2} = {2{DEF_DRIVE}};
        {m_drive_cn, m_drive_cn2, m_drive_mn, m_epsc_sn_mn, m_epsc_cn_mn} = '0;
        {m_cnt, m_sn_run, m_mn_run, m_sn_cnt, m_mn_cnt} = '0;
        m_ticks = 0;
        // reset rises after time zero, ahead of the first clock edge
        #1;
        reset_sim = 1'b1;
        repeat (2) @(posedge ep50trig);
        #1;
        reset_sim = 1'b0;
        check_outputs();
        // defaults, then loads with wraparound, then tick reloads, then settle
        run_phase(40, 0);
        run_phase(200, 1);
        run_phase(300, 2);
        run_phase(60, 0);
        if (UUT.u_drive_network.u_assert.fail_cnt == 0)
        begin
            $display("Simulation completed successfully");
            $finish;
        end
        else
        begin
            $display("Simulation failed");
            $fatal(1);
        end
    end

    // watchdog
    initial
    begin
        #(N_CYC * MAX_PER * 8 + 1000);
        $display("Timeout: the run did not finish within the expected time");
        $display("Simulation failed");
        $fatal(1);
    end

endmodule

// ==== flist.f ====
hw/reflex_pkg.sv
hw/param_bank.sv
hw/neuron_tick_gen.sv
hw/drive_network.sv
hw/spike_window_counter.sv
hw/reflex_loop_top.sv
bench/reflex_loop_assert.sv
bench/tb_reflex_loop.sv
